// File: sources.f
verilog/hc_pkg.sv
verilog/hc_fifo.sv
verilog/hc_read_engine.sv
verilog/hc_write_engine.sv
verilog/hc_control.sv
verilog/hc_requestor.sv
dv/hc_host_model.sv
dv/hc_requestor_tb.sv

// File: run.sh
#!/bin/sh
# Compile the requestor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module hc_requestor_tb -o hc_requestor_sim

./obj_dir/hc_requestor_sim | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: dv/hc_requestor_tb.sv
// Testbench for the host memory requestor with a host model and in-order checking
`default_nettype none

module hc_requestor_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [hc_pkg::HC_LINE_BITS-1:0] RSP_KEY = 64'h5A5A_0F0F_C3C3_9696;
  localparam int TOTAL_LINES = 61; // 36 read lines and 25 write lines
  localparam int CYCLE_LIMIT = 40 * TOTAL_LINES + 200;

  logic                              clk;
  logic                              reset;
  logic [31:0]                       control;
  logic [hc_pkg::HC_ADDR_BITS-1:0]   status_base;
  logic [hc_pkg::HC_ADDR_BITS-1:0]   buffer_address [hc_pkg::HC_NUM_BUFFERS];
  hc_pkg::hc_cmd_t                   rd_cmd;
  logic [hc_pkg::HC_ID_BITS-1:0]     rd_id;
  logic [hc_pkg::HC_OFFSET_BITS-1:0] rd_offset;
  hc_pkg::hc_cmd_t                   wr_cmd;
  logic [hc_pkg::HC_ID_BITS-1:0]     wr_id;
  logic [hc_pkg::HC_OFFSET_BITS-1:0] wr_offset;
  logic [hc_pkg::HC_LINE_BITS-1:0]   wr_data;
  logic                              finish;
  logic                              mem_rd_almost_full;
  logic                              mem_wr_almost_full;
  logic                              mem_rsp_valid;
  logic [hc_pkg::HC_LINE_BITS-1:0]   mem_rsp_data;
  logic                              started;
  logic                              done;
  logic                              rd_data_valid;
  logic [hc_pkg::HC_LINE_BITS-1:0]   rd_data;
  logic [hc_pkg::HC_COUNT_BITS-1:0]  rd_queue_count;
  logic                              rd_queue_empty;
  logic                              rd_queue_full;
  logic [hc_pkg::HC_COUNT_BITS-1:0]  wr_queue_count;
  logic                              wr_queue_empty;
  logic                              wr_queue_full;
  logic                              mem_rd_valid;
  logic [hc_pkg::HC_ADDR_BITS-1:0]   mem_rd_addr;
  logic                              mem_wr_valid;
  logic [hc_pkg::HC_ADDR_BITS-1:0]   mem_wr_addr;
  logic [hc_pkg::HC_LINE_BITS-1:0]   mem_wr_data;
  logic                              hold; // Holds both almost-full levels high

  logic [hc_pkg::HC_ADDR_BITS-1:0]   exp_rd_addr [$];
  logic [hc_pkg::HC_LINE_BITS-1:0]   exp_rsp [$];
  logic [hc_pkg::HC_ADDR_BITS-1:0]   exp_wr_addr [$];
  logic [hc_pkg::HC_LINE_BITS-1:0]   exp_wr_data [$];
  logic [hc_pkg::HC_OFFSET_BITS-1:0] wr_stream_line;
  logic                              rsp_seen;
  int addr_errors;
  int line_errors;
  int status_errors;
  int other_errors;
  int cycles;

  // ==================================================
  // Clock, DUT and host model
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  hc_requestor DUT (.*);

  hc_host_model #(.rsp_key(RSP_KEY)) u_host (
    .clk                (clk),
    .reset              (reset),
    .hold               (hold),
    .mem_rd_valid       (mem_rd_valid),
    .mem_rd_addr        (mem_rd_addr),
    .mem_rd_almost_full (mem_rd_almost_full),
    .mem_wr_almost_full (mem_wr_almost_full),
    .mem_rsp_valid      (mem_rsp_valid),
    .mem_rsp_data       (mem_rsp_data)
  );

  // ==================================================
  // Reference model and checks
  // ==================================================
  // Stream requests use the given line and indexed requests their own offset
  function automatic logic [hc_pkg::HC_ADDR_BITS-1:0] expected_addr(
    input logic [hc_pkg::HC_ID_BITS-1:0]     id,
    input hc_pkg::hc_cmd_t                   cmd,
    input logic [hc_pkg::HC_OFFSET_BITS-1:0] offset,
    input logic [hc_pkg::HC_OFFSET_BITS-1:0] stream_line
  );
    logic [hc_pkg::HC_OFFSET_BITS-1:0] line;
    line = (cmd == hc_pkg::HC_CMD_STREAM) ? stream_line : offset;
    return buffer_address[id] + {{(hc_pkg::HC_ADDR_BITS-hc_pkg::HC_OFFSET_BITS){1'b0}}, line};
  endfunction

  task automatic compare_addr(input string name, input logic [hc_pkg::HC_ADDR_BITS-1:0] got,
                              input logic [hc_pkg::HC_ADDR_BITS-1:0] expected);
    if (got !== expected) begin
      $display("error %0t %s: got %h expected %h", $time, name, got, expected);
      addr_errors++;
    end
  endtask

  task automatic compare_line(input string name, input logic [hc_pkg::HC_LINE_BITS-1:0] got,
                              input logic [hc_pkg::HC_LINE_BITS-1:0] expected);
    if (got !== expected) begin
      $display("error %0t %s: got %h expected %h", $time, name, got, expected);
      line_errors++;
    end
  endtask

  task automatic compare_count(input string name, input logic [hc_pkg::HC_COUNT_BITS-1:0] got,
                               input logic [hc_pkg::HC_COUNT_BITS-1:0] expected);
    if (got !== expected) begin
      $display("error %0t %s: got %0d expected %0d", $time, name, got, expected);
      status_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("error %0t %s: got %b expected %b", $time, name, got, expected);
      status_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%0t ns: %s", $time, what);
    other_errors++;
  endtask

  task automatic print_counts();
    $display("errors: address %0d, data %0d, status %0d, other %0d",
             addr_errors, line_errors, status_errors, other_errors);
  endtask

  // Host requests and read data are checked in order against the expected queues
  always @(posedge clk) begin
    if (!reset) begin
      if ((mem_rd_valid || mem_wr_valid) && !started) report_failure("host request before start");
      if (mem_rd_valid) begin
        if (exp_rd_addr.size() == 0) report_failure("host read issued with none expected");
        else compare_addr("mem_rd_addr", mem_rd_addr, exp_rd_addr.pop_front());
      end
      if (mem_wr_valid) begin
        if (exp_wr_addr.size() == 0) begin
          report_failure("host write issued with none expected");
        end else begin
          compare_addr("mem_wr_addr", mem_wr_addr, exp_wr_addr.pop_front());
          compare_line("mem_wr_data", mem_wr_data, exp_wr_data.pop_front());
        end
      end
      if (rd_data_valid !== rsp_seen) report_failure("rd_data_valid missed its response cycle");
      if (rd_data_valid) begin
        if (exp_rsp.size() == 0) report_failure("read data returned with none expected");
        else compare_line("rd_data", rd_data, exp_rsp.pop_front());
      end
      rsp_seen = mem_rsp_valid;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with host requests still outstanding", cycles);
    print_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic post_read(input hc_pkg::hc_cmd_t cmd, input logic [1:0] id,
                           input logic [hc_pkg::HC_OFFSET_BITS-1:0] offset);
    logic [hc_pkg::HC_ADDR_BITS-1:0] addr;
    while (rd_queue_full) begin
      @(posedge clk);
      #1;
    end
    for (int k = 0; k < ((cmd == hc_pkg::HC_CMD_STREAM) ? int'(offset) : 1); k++) begin
      addr = expected_addr(id, cmd, offset, k[hc_pkg::HC_OFFSET_BITS-1:0]);
      exp_rd_addr.push_back(addr);
      exp_rsp.push_back({32'd0, addr} ^ RSP_KEY);
    end
    rd_cmd    = cmd;
    rd_id     = id;
    rd_offset = offset;
    @(posedge clk);
    #1;
    rd_cmd = hc_pkg::HC_CMD_NONE;
  endtask

  task automatic post_write(input hc_pkg::hc_cmd_t cmd, input logic [1:0] id,
                            input logic [hc_pkg::HC_OFFSET_BITS-1:0] offset,
                            input logic [hc_pkg::HC_LINE_BITS-1:0] data);
    while (wr_queue_full) begin
      @(posedge clk);
      #1;
    end
    exp_wr_addr.push_back(expected_addr(id, cmd, offset, wr_stream_line));
    exp_wr_data.push_back(data);
    if (cmd == hc_pkg::HC_CMD_STREAM) wr_stream_line = wr_stream_line + 10'd1;
    wr_cmd    = cmd;
    wr_id     = id;
    wr_offset = offset;
    wr_data   = data;
    @(posedge clk);
    #1;
    wr_cmd = hc_pkg::HC_CMD_NONE;
  endtask

  task automatic wait_drained();
    while (exp_rd_addr.size() != 0 || exp_rsp.size() != 0 || exp_wr_addr.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    int ri;
    int wi;
    reset             = 1'b1;
    control           = '0;
    status_base       = 32'h00F0_0000;
    buffer_address[0] = 32'h0010_0000;
    buffer_address[1] = 32'h0014_0000;
    buffer_address[2] = 32'h0018_0000;
    buffer_address[3] = 32'h001C_0000;
    rd_cmd            = hc_pkg::HC_CMD_NONE;
    rd_id             = '0;
    rd_offset         = '0;
    wr_cmd            = hc_pkg::HC_CMD_NONE;
    wr_id             = '0;
    wr_offset         = '0;
    wr_data           = '0;
    finish            = 1'b0;
    hold              = 1'b0;
    wr_stream_line    = '0;
    rsp_seen          = 1'b0;
    addr_errors       = 0;
    line_errors       = 0;
    status_errors     = 0;
    other_errors      = 0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    compare_flag("started", started, 1'b0);
    compare_flag("done", done, 1'b0);
    compare_flag("mem_rd_valid", mem_rd_valid, 1'b0);
    compare_flag("mem_wr_valid", mem_wr_valid, 1'b0);
    compare_flag("rd_data_valid", rd_data_valid, 1'b0);

    // Requests posted before the start word wait in the queues
    post_read(hc_pkg::HC_CMD_INDEXED, 2'd1, 10'd5);
    post_write(hc_pkg::HC_CMD_INDEXED, 2'd2, 10'd9, 64'h0123_4567_89AB_CDEF);
    repeat (4) @(posedge clk);
    #1;
    compare_flag("started", started, 1'b0);
    control = hc_pkg::HC_CONTROL_START;
    @(posedge clk);
    #1;
    compare_flag("started", started, 1'b1);

    fork
      begin
        post_read(hc_pkg::HC_CMD_STREAM, 2'd0, 10'd12);
        post_read(hc_pkg::HC_CMD_STREAM, 2'd2, 10'd7);
        post_read(hc_pkg::HC_CMD_INDEXED, 2'd3, 10'd100);
        post_read(hc_pkg::HC_CMD_STREAM, 2'd3, 10'd1);
        post_read(hc_pkg::HC_CMD_INDEXED, 2'd0, 10'd1023);
      end
      for (wi = 0; wi < 10; wi++) begin
        post_write((wi % 3 == 2) ? hc_pkg::HC_CMD_INDEXED : hc_pkg::HC_CMD_STREAM, wi[1:0],
                   10'(wi * 37 + 3), {32'(32'hDA7A_0000 + wi), 32'(32'h0BAD_F00D ^ wi)});
      end
    join
    wait_drained();

    // Queues fill while the host holds back-pressure
    hold = 1'b1;
    @(posedge clk);
    #1;
    fork
      for (ri = 0; ri < 13; ri++) post_read(hc_pkg::HC_CMD_INDEXED, ri[1:0], 10'(ri * 3));
      for (wi = 0; wi < 13; wi++) begin
        post_write(wi[0] ? hc_pkg::HC_CMD_INDEXED : hc_pkg::HC_CMD_STREAM, wi[1:0],
                   10'(wi * 5), {32'(32'hC0DE_0000 + wi), 32'(32'h7E57_0000 ^ wi)});
      end
    join
    @(posedge clk);
    #1;
    compare_count("rd_queue_count", rd_queue_count, 5'd13);
    compare_flag("rd_queue_full", rd_queue_full, 1'b1);
    compare_flag("rd_queue_empty", rd_queue_empty, 1'b0);
    compare_count("wr_queue_count", wr_queue_count, 5'd13);
    compare_flag("wr_queue_full", wr_queue_full, 1'b1);
    compare_flag("wr_queue_empty", wr_queue_empty, 1'b0);
    hold = 1'b0;
    wait_drained();

    // Completion record goes out last
    exp_wr_addr.push_back(status_base);
    exp_wr_data.push_back(64'd1);
    finish = 1'b1;
    while (!done) begin
      @(posedge clk);
      #1;
    end
    if (exp_wr_addr.size() != 0) report_failure("done rose before the completion record");
    repeat (8) begin
      @(posedge clk);
      #1;
      compare_flag("done", done, 1'b1);
    end
    wait_drained();
    compare_flag("rd_queue_empty", rd_queue_empty, 1'b1);
    compare_flag("wr_queue_empty", wr_queue_empty, 1'b1);
    print_counts();
    if (addr_errors + line_errors + status_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/hc_host_model.sv
// Host memory model that applies random back-pressure and answers reads in order
`default_nettype none

module hc_host_model #(
  parameter logic [hc_pkg::HC_LINE_BITS-1:0] rsp_key = '0
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            hold,
  input  logic                            mem_rd_valid,
  input  logic [hc_pkg::HC_ADDR_BITS-1:0] mem_rd_addr,
  output logic                            mem_rd_almost_full,
  output logic                            mem_wr_almost_full,
  output logic                            mem_rsp_valid,
  output logic [hc_pkg::HC_LINE_BITS-1:0] mem_rsp_data
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [hc_pkg::HC_ADDR_BITS-1:0] pend_addr [$];
  int unsigned                     pend_due [$];
  int unsigned                     cycle;
  int unsigned                     due;
  int unsigned                     last_due;
  integer                          seed;
  logic [31:0]                     rnd;
  logic                            hold_q;

  initial begin
    seed               = 16;
    cycle              = 0;
    last_due           = 0;
    mem_rd_almost_full = 1'b0;
    mem_wr_almost_full = 1'b0;
    mem_rsp_valid      = 1'b0;
    mem_rsp_data       = '0;
  end

  always @(posedge clk) begin
    rnd    = $random(seed);
    cycle  = cycle + 1;
    hold_q = hold;
    if (reset) begin
      pend_addr.delete();
      pend_due.delete();
      last_due = 0;
    end else if (mem_rd_valid) begin
      due = cycle + 32'd2 + {30'd0, rnd[5:4]}; // Latency varies but answers stay in order
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      pend_addr.push_back(mem_rd_addr);
      pend_due.push_back(due);
    end
    #1;
    mem_rd_almost_full = hold_q || (rnd[1:0] == 2'b00);
    mem_wr_almost_full = hold_q || (rnd[3:2] == 2'b00);
    if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
      mem_rsp_valid = 1'b1;
      mem_rsp_data  = {32'd0, pend_addr.pop_front()} ^ rsp_key;
      void'(pend_due.pop_front());
    end else begin
      mem_rsp_valid = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/hc_requestor.sv
// Host memory requestor top with request queues, read and write engines and control
`default_nettype none

module hc_requestor (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [31:0]                      control,
  input  logic [hc_pkg::HC_ADDR_BITS-1:0]  status_base,
  input  logic [hc_pkg::HC_ADDR_BITS-1:0]  buffer_address [hc_pkg::HC_NUM_BUFFERS],
  input  hc_pkg::hc_cmd_t                  rd_cmd,
  input  logic [hc_pkg::HC_ID_BITS-1:0]    rd_id,
  input  logic [hc_pkg::HC_OFFSET_BITS-1:0] rd_offset,
  input  hc_pkg::hc_cmd_t                  wr_cmd,
  input  logic [hc_pkg::HC_ID_BITS-1:0]    wr_id,
  input  logic [hc_pkg::HC_OFFSET_BITS-1:0] wr_offset,
  input  logic [hc_pkg::HC_LINE_BITS-1:0]  wr_data,
  input  logic                             finish,
  input  logic                             mem_rd_almost_full,
  input  logic                             mem_wr_almost_full,
  input  logic                             mem_rsp_valid,
  input  logic [hc_pkg::HC_LINE_BITS-1:0]  mem_rsp_data,
  output logic                             started,
  output logic                             done,
  output logic                             rd_data_valid,
  output logic [hc_pkg::HC_LINE_BITS-1:0]  rd_data,
  output logic [hc_pkg::HC_COUNT_BITS-1:0] rd_queue_count,
  output logic                             rd_queue_empty,
  output logic                             rd_queue_full,
  output logic [hc_pkg::HC_COUNT_BITS-1:0] wr_queue_count,
  output logic                             wr_queue_empty,
  output logic                             wr_queue_full,
  output logic                             mem_rd_valid,
  output logic [hc_pkg::HC_ADDR_BITS-1:0]  mem_rd_addr,
  output logic                             mem_wr_valid,
  output logic [hc_pkg::HC_ADDR_BITS-1:0]  mem_wr_addr,
  output logic [hc_pkg::HC_LINE_BITS-1:0]  mem_wr_data
);

  hc_pkg::hc_rd_request_t rd_enq_data;
  hc_pkg::hc_rd_request_t rd_deq_data;
  hc_pkg::hc_wr_request_t wr_enq_data;
  hc_pkg::hc_wr_request_t wr_deq_data;

  logic [hc_pkg::HC_COUNT_BITS-1:0] rd_count;
  logic [hc_pkg::HC_COUNT_BITS-1:0] wr_count;

  logic rd_not_empty;
  logic wr_not_empty;
  logic rd_deq;
  logic wr_deq;
  logic run;
  logic report_req;
  logic report_sent;

  assign rd_enq_data = '{cmd: rd_cmd, id: rd_id, offset: rd_offset};
  assign wr_enq_data = '{cmd: wr_cmd, id: wr_id, offset: wr_offset, data: wr_data};

  // ==================================================
  // Request queues and their status
  // ==================================================
  hc_fifo #(.payload_t(hc_pkg::hc_rd_request_t)) u_rd_queue (
    .clk       (clk),
    .reset     (reset),
    .enq       (rd_cmd != hc_pkg::HC_CMD_NONE),
    .enq_data  (rd_enq_data),
    .deq       (rd_deq),
    .deq_data  (rd_deq_data),
    .not_empty (rd_not_empty),
    .count     (rd_count)
  );

  hc_fifo #(.payload_t(hc_pkg::hc_wr_request_t)) u_wr_queue (
    .clk       (clk),
    .reset     (reset),
    .enq       (wr_cmd != hc_pkg::HC_CMD_NONE),
    .enq_data  (wr_enq_data),
    .deq       (wr_deq),
    .deq_data  (wr_deq_data),
    .not_empty (wr_not_empty),
    .count     (wr_count)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_queue_count <= '0;
      rd_queue_empty <= 1'b1;
      rd_queue_full  <= 1'b0;
      wr_queue_count <= '0;
      wr_queue_empty <= 1'b1;
      wr_queue_full  <= 1'b0;
    end else begin
      rd_queue_count <= rd_count;
      rd_queue_empty <= !rd_not_empty;
      rd_queue_full  <= (rd_count > hc_pkg::HC_FULL_LEVEL);
      wr_queue_count <= wr_count;
      wr_queue_empty <= !wr_not_empty;
      wr_queue_full  <= (wr_count > hc_pkg::HC_FULL_LEVEL);
    end
  end

  // ==================================================
  // Engines and sequencer
  // ==================================================
  hc_read_engine u_read_engine (
    .clk            (clk),
    .reset          (reset),
    .run            (run),
    .buffer_address (buffer_address),
    .request        (rd_deq_data),
    .request_ready  (rd_not_empty),
    .deq            (rd_deq),
    .almost_full    (mem_rd_almost_full),
    .mem_rd_valid   (mem_rd_valid),
    .mem_rd_addr    (mem_rd_addr),
    .rsp_valid      (mem_rsp_valid),
    .rsp_data       (mem_rsp_data),
    .data_valid     (rd_data_valid),
    .data           (rd_data)
  );

  hc_write_engine u_write_engine (
    .clk            (clk),
    .reset          (reset),
    .run            (run),
    .buffer_address (buffer_address),
    .status_base    (status_base),
    .request        (wr_deq_data),
    .request_ready  (wr_not_empty),
    .deq            (wr_deq),
    .almost_full    (mem_wr_almost_full),
    .report_req     (report_req),
    .report_sent    (report_sent),
    .mem_wr_valid   (mem_wr_valid),
    .mem_wr_addr    (mem_wr_addr),
    .mem_wr_data    (mem_wr_data)
  );

  hc_control u_control (
    .clk           (clk),
    .reset         (reset),
    .control       (control),
    .finish        (finish),
    .write_pending (wr_not_empty), // Report waits for the write queue to drain
    .report_sent   (report_sent),
    .run           (run),
    .started       (started),
    .report_req    (report_req),
    .done          (done)
  );

endmodule

`default_nettype wire

// File: verilog/hc_control.sv
// Run and finish sequencer that starts the engines and orders the completion write
`default_nettype none

module hc_control (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] control,
  input  logic        finish,
  input  logic        write_pending,
  input  logic        report_sent,
  output logic        run,
  output logic        started,
  output logic        report_req,
  output logic        done
);

  hc_pkg::hc_run_state_t state;
  hc_pkg::hc_run_state_t next_state;

  always_comb begin
    next_state = state;
    case (state)
      hc_pkg::CTL_IDLE:   if (started) next_state = hc_pkg::CTL_RUN;
      hc_pkg::CTL_RUN:    if (finish && !write_pending) next_state = hc_pkg::CTL_REPORT;
      hc_pkg::CTL_REPORT: if (report_sent) next_state = hc_pkg::CTL_DONE;
      default:            next_state = hc_pkg::CTL_DONE; // Done holds until reset
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= hc_pkg::CTL_IDLE;
      started    <= 1'b0;
      report_req <= 1'b0;
    end else begin
      state      <= next_state;
      started    <= (control == hc_pkg::HC_CONTROL_START);
      // One pulse as the sequencer enters the report state
      report_req <= (state == hc_pkg::CTL_RUN) && (next_state == hc_pkg::CTL_REPORT);
    end
  end

  assign run  = (state == hc_pkg::CTL_RUN) || (state == hc_pkg::CTL_REPORT);
  assign done = (state == hc_pkg::CTL_DONE);

  // The write engine answers only a report that was requested
  a_report_order : assert property (@(posedge clk) disable iff (reset)
    report_sent |-> (state == hc_pkg::CTL_REPORT))
    else $error("Completion record sent outside the report state");

endmodule

`default_nettype wire

// File: verilog/hc_write_engine.sv
// Write engine that issues queued line writes and the completion record
`default_nettype none

module hc_write_engine (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            run,
  input  logic [hc_pkg::HC_ADDR_BITS-1:0] buffer_address [hc_pkg::HC_NUM_BUFFERS],
  input  logic [hc_pkg::HC_ADDR_BITS-1:0] status_base,
  input  hc_pkg::hc_wr_request_t          request,
  input  logic                            request_ready,
  output logic                            deq,
  input  logic                            almost_full,
  input  logic                            report_req,
  output logic                            report_sent,
  output logic                            mem_wr_valid,
  output logic [hc_pkg::HC_ADDR_BITS-1:0] mem_wr_addr,
  output logic [hc_pkg::HC_LINE_BITS-1:0] mem_wr_data
);

  logic [hc_pkg::HC_OFFSET_BITS-1:0] stream_cnt;
  logic [hc_pkg::HC_OFFSET_BITS-1:0] line_offset;
  logic                              report_pending;
  logic                              send_report;
  logic                              is_stream;

  assign is_stream   = (request.cmd == hc_pkg::HC_CMD_STREAM);
  assign line_offset = is_stream ? stream_cnt : request.offset;

  // No new line is taken once a report is waiting
  assign deq         = run && request_ready && !almost_full && !report_pending;
  assign send_report = report_pending && !almost_full;

  // ==================================================
  // Control state
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stream_cnt     <= '0;
      report_pending <= 1'b0;
      report_sent    <= 1'b0;
      mem_wr_valid   <= 1'b0;
    end else begin
      if (!run) begin
        stream_cnt <= '0; // Running line counter restarts with each run
      end else if (deq && is_stream) begin
        stream_cnt <= stream_cnt + 1'b1;
      end
      if (send_report) begin
        report_pending <= 1'b0;
      end else if (report_req) begin
        report_pending <= 1'b1;
      end
      report_sent  <= send_report;
      mem_wr_valid <= deq || send_report;
    end
  end

  // ==================================================
  // Output stage
  // ==================================================
  always_ff @(posedge clk) begin
    if (send_report) begin
      mem_wr_addr <= status_base;
      mem_wr_data <= hc_pkg::HC_REPORT_DATA;
    end else if (deq) begin
      mem_wr_addr <= hc_pkg::hc_line_addr(buffer_address[request.id], line_offset);
      mem_wr_data <= request.data;
    end
  end

  a_wr_backpressure : assert property (@(posedge clk) disable iff (reset)
    mem_wr_valid |-> !$past(almost_full))
    else $error("Host write issued under back-pressure");

endmodule

`default_nettype wire

// File: verilog/hc_read_engine.sv
// Read engine that turns queued stream and indexed reads into host line reads
`default_nettype none

module hc_read_engine (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            run,
  input  logic [hc_pkg::HC_ADDR_BITS-1:0] buffer_address [hc_pkg::HC_NUM_BUFFERS],
  input  hc_pkg::hc_rd_request_t          request,
  input  logic                            request_ready,
  output logic                            deq,
  input  logic                            almost_full,
  output logic                            mem_rd_valid,
  output logic [hc_pkg::HC_ADDR_BITS-1:0] mem_rd_addr,
  input  logic                            rsp_valid,
  input  logic [hc_pkg::HC_LINE_BITS-1:0] rsp_data,
  output logic                            data_valid,
  output logic [hc_pkg::HC_LINE_BITS-1:0] data
);

  hc_pkg::hc_rd_state_t   state;
  hc_pkg::hc_rd_state_t   next_state;
  hc_pkg::hc_rd_request_t current;

  logic [hc_pkg::HC_OFFSET_BITS-1:0] line_cnt;
  logic [hc_pkg::HC_OFFSET_BITS-1:0] issue_offset;
  logic                              issue;

  assign deq   = run && request_ready && !almost_full && (state == hc_pkg::RD_IDLE);
  assign issue = !almost_full && (state != hc_pkg::RD_IDLE);
  assign issue_offset = (state == hc_pkg::RD_STREAM) ? line_cnt : current.offset;

  always_comb begin
    next_state = state;
    case (state)
      hc_pkg::RD_IDLE: begin
        if (deq) begin
          if (request.cmd == hc_pkg::HC_CMD_INDEXED) begin
            next_state = hc_pkg::RD_INDEX;
          end else if (request.offset != '0) begin // An empty stream is dropped
            next_state = hc_pkg::RD_STREAM;
          end
        end
      end
      hc_pkg::RD_STREAM: begin
        if (!almost_full && (line_cnt + 1'b1 == current.offset)) next_state = hc_pkg::RD_IDLE;
      end
      default: begin
        if (!almost_full) next_state = hc_pkg::RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= hc_pkg::RD_IDLE;
      line_cnt     <= '0;
      mem_rd_valid <= 1'b0;
      data_valid   <= 1'b0;
    end else begin
      state        <= next_state;
      mem_rd_valid <= issue;
      data_valid   <= rsp_valid;
      if (state == hc_pkg::RD_IDLE) begin
        line_cnt <= '0;
      end else if (state == hc_pkg::RD_STREAM && !almost_full) begin
        line_cnt <= line_cnt + 1'b1; // Held while the host pushes back
      end
    end
  end

  always_ff @(posedge clk) begin
    if (deq) current <= request;
    if (issue) mem_rd_addr <= hc_pkg::hc_line_addr(buffer_address[current.id], issue_offset);
    if (rsp_valid) data <= rsp_data;
  end

  // A read line may only follow a cycle with the almost-full level low
  a_rd_backpressure : assert property (@(posedge clk) disable iff (reset)
    mem_rd_valid |-> !$past(almost_full))
    else $error("Host read issued under back-pressure");

endmodule

`default_nettype wire

// File: verilog/hc_fifo.sv
// Request queue as a circular buffer with show-ahead output and an occupancy count
`default_nettype none

module hc_fifo #(
  parameter type payload_t = logic
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             enq,
  input  payload_t                         enq_data,
  input  logic                             deq,
  output payload_t                         deq_data,
  output logic                             not_empty,
  output logic [hc_pkg::HC_COUNT_BITS-1:0] count
);

  payload_t mem [hc_pkg::HC_REQUEST_DEPTH];

  logic [hc_pkg::HC_PTR_BITS-1:0] wr_ptr;
  logic [hc_pkg::HC_PTR_BITS-1:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (enq) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the depth
      if (deq) rd_ptr <= rd_ptr + 1'b1;
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign deq_data  = mem[rd_ptr];
  assign not_empty = (count != '0);

  // ==================================================
  // Producer and consumer checks
  // ==================================================
  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    enq |-> (count != hc_pkg::HC_DEPTH_COUNT) || deq)
    else $error("Request posted into a full queue");

  a_no_underflow : assert property (@(posedge clk) disable iff (reset)
    deq |-> not_empty)
    else $error("Dequeue from an empty queue");

endmodule

`default_nettype wire

// File: verilog/hc_pkg.sv
// Host channel requestor definitions shared by the queues, engines and control
`default_nettype none

package hc_pkg;

  // ==================================================
  // Widths and sizes
  // ==================================================
  localparam int HC_ADDR_BITS     = 32;
  localparam int HC_LINE_BITS     = 64;
  localparam int HC_NUM_BUFFERS   = 4;
  localparam int HC_ID_BITS       = 2;
  localparam int HC_OFFSET_BITS   = 10;
  localparam int HC_REQUEST_DEPTH = 16;
  localparam int HC_COUNT_BITS    = 5;
  localparam int HC_PTR_BITS      = $clog2(HC_REQUEST_DEPTH);
  localparam int HC_FULL_MARGIN   = 4;

  localparam logic [HC_COUNT_BITS-1:0] HC_DEPTH_COUNT = HC_COUNT_BITS'(HC_REQUEST_DEPTH);
  // Full status rises once the count passes this level
  localparam logic [HC_COUNT_BITS-1:0] HC_FULL_LEVEL =
    HC_COUNT_BITS'(HC_REQUEST_DEPTH - HC_FULL_MARGIN);

  localparam logic [31:0]             HC_CONTROL_START = 32'h0000_0001;
  localparam logic [HC_LINE_BITS-1:0] HC_REPORT_DATA   = HC_LINE_BITS'(1); // Completion record

  // ==================================================
  // Encodings and request records
  // ==================================================
  typedef enum logic [1:0] {
    HC_CMD_NONE    = 2'd0,
    HC_CMD_STREAM  = 2'd1,
    HC_CMD_INDEXED = 2'd2
  } hc_cmd_t;

  typedef struct packed {
    hc_cmd_t                   cmd;
    logic [HC_ID_BITS-1:0]     id;
    logic [HC_OFFSET_BITS-1:0] offset; // Line offset, or length of a stream
  } hc_rd_request_t;

  typedef struct packed {
    hc_cmd_t                   cmd;
    logic [HC_ID_BITS-1:0]     id;
    logic [HC_OFFSET_BITS-1:0] offset;
    logic [HC_LINE_BITS-1:0]   data;
  } hc_wr_request_t;

  typedef enum logic [1:0] {RD_IDLE, RD_STREAM, RD_INDEX} hc_rd_state_t;

  typedef enum logic [1:0] {CTL_IDLE, CTL_RUN, CTL_REPORT, CTL_DONE} hc_run_state_t;

  // Host line address of a buffer base plus a line offset
  function automatic logic [HC_ADDR_BITS-1:0] hc_line_addr(
    input logic [HC_ADDR_BITS-1:0]   base,
    input logic [HC_OFFSET_BITS-1:0] offset
  );
    return base + HC_ADDR_BITS'(offset);
  endfunction

endpackage

`default_nettype wire
